/* logic/sd_pkg.sv */
`default_nettype none

package sd_pkg;

  localparam int BLOCK_BITS = 4096;      // 512 bytes
  localparam int CMD_FRAME_BITS = 48;

  typedef logic [31:0] sd_addr_t;        // Block address, SDHC style
  typedef logic [5:0] sd_cmd_index_t;
  typedef logic [31:0] sd_arg_t;
  typedef logic [7:0] sd_r1_t;
  typedef logic [6:0] sd_crc7_t;
  typedef logic [15:0] sd_crc16_t;
  typedef logic [BLOCK_BITS-1:0] sd_block_t;  // Byte 0 in bits [7:0], sent first

  typedef struct packed {
    sd_cmd_index_t index;
    sd_arg_t       arg;
  } sd_cmd_t;

  typedef enum logic {TX_CMD, TX_DATA} sd_tx_kind_t;

  typedef enum logic [1:0] {RX_R1, RX_R7, RX_DATA, RX_DATA_RESP} sd_rx_kind_t;

  typedef struct packed {
    sd_r1_t      r1;
    logic [31:0] r7;         // R7 bytes after the R1
    logic [2:0]  data_resp;  // Status field of the data-response token
    logic        crc_error;
  } sd_rx_result_t;

  localparam sd_arg_t CMD8_ARG = 32'h0000_01AA;     // 2.7-3.6 V, check pattern AA
  localparam sd_arg_t ACMD41_ARG = 32'h4000_0000;   // HCS
  localparam logic [7:0] DATA_START_TOKEN = 8'hFE;
  localparam logic [2:0] DATA_ACCEPTED = 3'b010;
  localparam int POWER_UP_CLOCKS = 80;

  // Polynomial x^7 + x^3 + 1
  function automatic sd_crc7_t crc7_next(sd_crc7_t crc, logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

  // CCITT polynomial x^16 + x^12 + x^5 + 1
  function automatic sd_crc16_t crc16_next(sd_crc16_t crc, logic din);
    logic fb;
    fb = din ^ crc[15];
    return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
  endfunction

endpackage

`default_nettype wire

/* logic/sd_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_clock_gen #(
  parameter int SLOW_DIV = 64,  // System cycles per SCK half period
  parameter int FAST_DIV = 2
) (
  input  logic clock,
  input  logic reset,
  input  logic fast,
  input  logic sck_enable,
  output logic sck,
  output logic shift_tick,
  output logic sample_tick
);

  localparam int MAX_DIV = (SLOW_DIV > FAST_DIV) ? SLOW_DIV : FAST_DIV;
  localparam int CNT_W = $clog2(MAX_DIV) + 1;

  logic [CNT_W-1:0] div_cnt;
  logic [CNT_W-1:0] half_period;

  assign half_period = fast ? CNT_W'(FAST_DIV - 1) : CNT_W'(SLOW_DIV - 1);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_cnt     <= '0;
      sck         <= 1'b0;
      shift_tick  <= 1'b0;
      sample_tick <= 1'b0;
    end else begin
      shift_tick  <= 1'b0;
      sample_tick <= 1'b0;
      if (!sck_enable) begin
        div_cnt <= '0;
        sck     <= 1'b0;  // SPI mode 0 idles low
      end else if (div_cnt >= half_period) begin  // >= covers a rate change mid count
        div_cnt     <= '0;
        sck         <= ~sck;
        sample_tick <= ~sck;  // Rising edge
        shift_tick  <= sck;   // Falling edge
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sd_sender.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_sender
  import sd_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        shift_tick,
  input  logic        tx_start,
  input  sd_tx_kind_t tx_kind,
  input  sd_cmd_t     cmd,
  input  sd_block_t   block,
  output logic        mosi,
  output logic        sending
);

  localparam int HEAD_BITS = 40;  // Start, transmission bit, index, argument
  localparam int CMD_LAST = CMD_FRAME_BITS - 1;
  localparam int DATA_CRC_START = 8 + BLOCK_BITS;
  localparam int DATA_LAST = DATA_CRC_START + 16 - 1;

  sd_tx_kind_t kind_q;
  sd_cmd_t     cmd_q;
  sd_crc16_t   crc_q;      // CRC7 lives in the low 7 bits for commands
  logic [12:0] bit_cnt;    // Index of the next bit to drive
  logic [12:0] last_cnt;
  logic [11:0] data_idx;
  logic [39:0] cmd_head;
  logic        tx_bit;
  logic        in_payload;
  logic        in_crc;

  assign cmd_head = {2'b01, cmd_q.index, cmd_q.arg};
  assign data_idx = 12'(bit_cnt - 13'd8);
  assign last_cnt = (kind_q == TX_CMD) ? 13'(CMD_LAST) : 13'(DATA_LAST);

  // Bit to put on the wire for the current position
  always_comb begin
    tx_bit     = 1'b1;  // End bit of a command frame
    in_payload = 1'b0;
    in_crc     = 1'b0;
    if (kind_q == TX_CMD) begin
      if (bit_cnt < 13'(HEAD_BITS)) begin
        tx_bit     = cmd_head[6'd39 - bit_cnt[5:0]];
        in_payload = 1'b1;
      end else if (bit_cnt < 13'(CMD_LAST)) begin
        tx_bit = crc_q[6];
        in_crc = 1'b1;
      end
    end else begin
      if (bit_cnt < 13'd8) begin
        tx_bit = DATA_START_TOKEN[~bit_cnt[2:0]];
      end else if (bit_cnt < 13'(DATA_CRC_START)) begin
        tx_bit     = block[{data_idx[11:3], ~data_idx[2:0]}];  // MSB of each byte first
        in_payload = 1'b1;
      end else begin
        tx_bit = crc_q[15];
        in_crc = 1'b1;
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sending <= 1'b0;
      bit_cnt <= '0;
      mosi    <= 1'b1;
    end else if (tx_start) begin
      sending <= 1'b1;
      bit_cnt <= '0;
    end else if (sending && shift_tick) begin
      if (bit_cnt > last_cnt) begin  // Last bit has had its full SCK period
        sending <= 1'b0;
        mosi    <= 1'b1;
      end else begin
        mosi    <= tx_bit;
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (tx_start) begin
      cmd_q  <= cmd;
      kind_q <= tx_kind;
      crc_q  <= '0;
    end else if (sending && shift_tick) begin
      if (in_payload) begin
        if (kind_q == TX_CMD) crc_q[6:0] <= crc7_next(crc_q[6:0], tx_bit);
        else crc_q <= crc16_next(crc_q, tx_bit);
      end else if (in_crc) begin
        crc_q <= {crc_q[14:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sd_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_receiver
  import sd_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          sample_tick,
  input  logic          miso,
  input  logic          rx_start,
  input  sd_rx_kind_t   rx_kind,
  output sd_rx_result_t rx_result,
  output sd_block_t     rx_block,
  output logic          rx_done
);

  typedef enum logic [2:0] {
    R_IDLE, R_HUNT, R_COLLECT, R_TOKEN, R_BLOCK, R_CRC, R_BUSY
  } rx_state_t;

  rx_state_t   state;
  sd_rx_kind_t kind_q;
  logic [11:0] bit_cnt;
  logic [11:0] resp_last;
  logic [39:0] shreg;
  logic [39:0] shreg_next;
  sd_crc16_t   crc_q;

  assign shreg_next = {shreg[38:0], miso};

  always_comb begin
    case (kind_q)
      RX_R7:        resp_last = 12'd39;
      RX_DATA_RESP: resp_last = 12'd4;   // 0sss1
      default:      resp_last = 12'd7;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= R_IDLE;
      kind_q  <= RX_R1;
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (rx_start) begin
        kind_q  <= rx_kind;
        bit_cnt <= '0;
        state   <= (rx_kind == RX_DATA) ? R_TOKEN : R_HUNT;
      end else if (sample_tick) begin
        case (state)
          R_HUNT: if (!miso) begin  // First zero is the response MSB
            bit_cnt <= 12'd1;
            state   <= R_COLLECT;
          end
          R_COLLECT: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == resp_last) begin
              if (kind_q == RX_DATA_RESP) begin
                state <= R_BUSY;
              end else begin
                rx_done <= 1'b1;
                state   <= R_IDLE;
              end
            end
          end
          R_TOKEN: if (shreg_next[7:0] == DATA_START_TOKEN) begin
            bit_cnt <= '0;
            state   <= R_BLOCK;
          end
          R_BLOCK: begin
            bit_cnt <= bit_cnt + 1'b1;  // Wraps to zero for the CRC
            if (bit_cnt == 12'hFFF) state <= R_CRC;
          end
          R_CRC: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 12'd15) begin
              rx_done <= 1'b1;
              state   <= R_IDLE;
            end
          end
          R_BUSY: if (miso) begin  // Card released busy
            rx_done <= 1'b1;
            state   <= R_IDLE;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_start) begin
      shreg <= '1;
    end else if (sample_tick) begin
      if (state != R_IDLE && state != R_BUSY) shreg <= shreg_next;
      case (state)
        R_TOKEN: crc_q <= '0;
        R_BLOCK: begin
          crc_q <= crc16_next(crc_q, miso);
          if (bit_cnt[2:0] == 3'd7) rx_block <= {shreg_next[7:0], rx_block[BLOCK_BITS-1:8]};
        end
        R_CRC: if (bit_cnt == 12'd15) rx_result.crc_error <= (shreg_next[15:0] != crc_q);
        R_COLLECT: if (bit_cnt == resp_last) begin
          case (kind_q)
            RX_R7: begin
              rx_result.r1 <= shreg_next[39:32];
              rx_result.r7 <= shreg_next[31:0];
            end
            RX_DATA_RESP: rx_result.data_resp <= shreg_next[3:1];
            default:      rx_result.r1 <= shreg_next[7:0];
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/sd_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_controller
  import sd_pkg::*;
#(
  parameter int MAX_RETRIES = 2
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          rd_en,
  input  logic          wr_en,
  input  logic          sending,
  input  logic          rx_done,
  input  sd_addr_t      addr,
  input  sd_rx_result_t rx_result,
  input  sd_block_t     rx_block,
  output logic          tx_start,
  output sd_tx_kind_t   tx_kind,
  output sd_cmd_t       cmd,
  output logic          rx_start,
  output sd_rx_kind_t   rx_kind,
  output logic          sck_enable,
  output logic          fast,
  output logic          cs,
  output logic          busy,
  output logic          done,
  output logic          error,
  output logic          ready,
  output sd_block_t     read_data
);

  // Power-up clocks come from whole all-ones frames sent with cs high
  localparam int POWER_FRAMES = (POWER_UP_CLOCKS + CMD_FRAME_BITS - 1) / CMD_FRAME_BITS;
  localparam int FRAME_W = (POWER_FRAMES > 1) ? $clog2(POWER_FRAMES) : 1;
  localparam int RETRY_W = (MAX_RETRIES > 0) ? $clog2(MAX_RETRIES + 1) : 1;
  localparam sd_cmd_t IDLE_FRAME = '1;

  typedef enum logic [4:0] {
    S_PU_SEND, S_PU_WAIT, S_CMD0, S_CHK0, S_CMD8, S_CHK8, S_CMD55, S_CHK55,
    S_ACMD41, S_CHK41, S_IDLE, S_CMD17, S_CHK17, S_CHK_RD, S_CMD24, S_CHK24,
    S_CHK_WR, S_WAIT_TX, S_RX_START, S_WAIT_RX, S_FINISH
  } state_t;

  state_t               state, next_state, ret_state, ret_next;
  sd_rx_kind_t          rx_kind_next;
  logic [FRAME_W-1:0]   frame_cnt;
  logic [RETRY_W-1:0]   retry_cnt;
  logic                 op_err;
  logic                 issue;
  logic                 set_err;
  logic                 accept;
  logic                 retry;
  logic                 frame_done;
  logic                 go_fast;

  assign read_data  = rx_block;
  assign sck_enable = !(state inside {S_IDLE, S_FINISH});

  always_comb begin
    next_state   = state;
    ret_next     = ret_state;
    rx_kind_next = rx_kind;
    tx_kind      = TX_CMD;
    cmd          = '0;
    issue        = 1'b0;
    rx_start     = 1'b0;
    set_err      = 1'b0;
    accept       = 1'b0;
    retry        = 1'b0;
    frame_done   = 1'b0;
    go_fast      = 1'b0;
    case (state)
      S_PU_SEND: begin
        cmd   = IDLE_FRAME;
        issue = 1'b1;
      end
      S_PU_WAIT: if (!sending) begin
        frame_done = 1'b1;
        next_state = (frame_cnt == FRAME_W'(POWER_FRAMES - 1)) ? S_CMD0 : S_PU_SEND;
      end
      S_CMD0: begin
        issue    = 1'b1;
        ret_next = S_CHK0;
      end
      S_CHK0: next_state = (rx_result.r1 == 8'h01) ? S_CMD8 : S_CMD0;
      S_CMD8: begin
        cmd          = '{index: 6'd8, arg: CMD8_ARG};
        issue        = 1'b1;
        rx_kind_next = RX_R7;
        ret_next     = S_CHK8;
      end
      S_CHK8: begin
        if (rx_result.r1 != 8'h01 || rx_result.r7[7:0] != CMD8_ARG[7:0]) next_state = S_CMD8;
        else if (rx_result.r7[11:8] != CMD8_ARG[11:8]) next_state = S_CMD0;  // Voltage
        else next_state = S_CMD55;
      end
      S_CMD55: begin
        cmd.index = 6'd55;
        issue     = 1'b1;
        ret_next  = S_CHK55;
      end
      S_CHK55: next_state = (rx_result.r1 == 8'h01) ? S_ACMD41 : S_CMD55;
      S_ACMD41: begin
        cmd      = '{index: 6'd41, arg: ACMD41_ARG};
        issue    = 1'b1;
        ret_next = S_CHK41;
      end
      S_CHK41: begin
        if (rx_result.r1 == 8'h00) begin  // Card left idle
          go_fast    = 1'b1;
          next_state = S_IDLE;
        end else begin
          next_state = S_CMD55;
        end
      end
      S_IDLE: if ((rd_en || wr_en) && ready && !busy) begin
        accept     = 1'b1;
        next_state = wr_en ? S_CMD24 : S_CMD17;
      end
      S_CMD17: begin
        cmd      = '{index: 6'd17, arg: addr};
        issue    = 1'b1;
        ret_next = S_CHK17;
      end
      S_CHK17: begin
        if (rx_result.r1 == 8'h00) begin
          rx_kind_next = RX_DATA;
          ret_next     = S_CHK_RD;
          next_state   = S_RX_START;
        end else begin
          set_err    = 1'b1;
          next_state = S_FINISH;
        end
      end
      S_CHK_RD: begin
        if (!rx_result.crc_error) begin
          next_state = S_FINISH;
        end else if (retry_cnt < RETRY_W'(MAX_RETRIES)) begin
          retry      = 1'b1;
          next_state = S_CMD17;
        end else begin
          set_err    = 1'b1;
          next_state = S_FINISH;
        end
      end
      S_CMD24: begin
        cmd      = '{index: 6'd24, arg: addr};
        issue    = 1'b1;
        ret_next = S_CHK24;
      end
      S_CHK24: begin
        if (rx_result.r1 == 8'h00) begin
          tx_kind      = TX_DATA;
          issue        = 1'b1;
          rx_kind_next = RX_DATA_RESP;
          ret_next     = S_CHK_WR;
        end else begin
          set_err    = 1'b1;
          next_state = S_FINISH;
        end
      end
      S_CHK_WR: begin
        set_err    = (rx_result.data_resp != DATA_ACCEPTED);
        next_state = S_FINISH;
      end
      S_WAIT_TX:  if (!sending) next_state = S_RX_START;
      S_RX_START: begin
        rx_start   = 1'b1;
        next_state = S_WAIT_RX;
      end
      S_WAIT_RX:  if (rx_done) next_state = ret_state;
      S_FINISH:   next_state = S_IDLE;
      default:    next_state = S_PU_SEND;
    endcase
    // Command states all hand a frame to the sender and wait for it
    if (issue) begin
      if (state != S_CMD8 && state != S_CHK24) rx_kind_next = RX_R1;
      next_state = (state == S_PU_SEND) ? S_PU_WAIT : S_WAIT_TX;
    end
  end

  assign tx_start = issue;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= S_PU_SEND;
      ret_state <= S_CMD0;
      rx_kind   <= RX_R1;
      frame_cnt <= '0;
      retry_cnt <= '0;
      op_err    <= 1'b0;
      cs        <= 1'b1;
      fast      <= 1'b0;
      ready     <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      error     <= 1'b0;
    end else begin
      state     <= next_state;
      ret_state <= ret_next;
      rx_kind   <= rx_kind_next;
      cs        <= next_state inside {S_PU_SEND, S_PU_WAIT, S_IDLE};
      done      <= (state == S_FINISH);
      if (frame_done) frame_cnt <= frame_cnt + 1'b1;
      if (retry) retry_cnt <= retry_cnt + 1'b1;
      if (set_err) op_err <= 1'b1;
      if (go_fast) begin
        fast  <= 1'b1;
        ready <= 1'b1;
      end
      if (accept) begin
        busy      <= 1'b1;
        op_err    <= 1'b0;
        retry_cnt <= '0;
      end
      if (state == S_FINISH) begin  // busy falls with done
        busy  <= 1'b0;
        error <= op_err;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/sd_host_top.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_host_top
  import sd_pkg::*;
#(
  parameter int SLOW_DIV    = 64,
  parameter int FAST_DIV    = 2,
  parameter int MAX_RETRIES = 2
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      rd_en,
  input  logic      wr_en,
  input  sd_addr_t  addr,
  input  sd_block_t write_data,
  output sd_block_t read_data,
  output logic      busy,
  output logic      done,
  output logic      error,
  output logic      ready,
  input  logic      miso,
  output logic      cs,
  output logic      sck,
  output logic      mosi
);

  logic          tx_start;
  sd_tx_kind_t   tx_kind;
  sd_cmd_t       cmd;
  logic          sending;
  logic          rx_start;
  sd_rx_kind_t   rx_kind;
  sd_rx_result_t rx_result;
  sd_block_t     rx_block;
  logic          rx_done;
  logic          sck_enable;
  logic          fast;
  logic          shift_tick;
  logic          sample_tick;

  sd_controller #(
    .MAX_RETRIES(MAX_RETRIES)
  ) u_sd_controller (
    .clock, .reset, .rd_en, .wr_en, .sending, .rx_done, .addr, .rx_result, .rx_block,
    .tx_start, .tx_kind, .cmd, .rx_start, .rx_kind, .sck_enable, .fast, .cs,
    .busy, .done, .error, .ready, .read_data
  );

  sd_sender u_sd_sender (
    .clock, .reset, .shift_tick, .tx_start, .tx_kind, .cmd,
    .block(write_data),  // Client holds it stable until done
    .mosi, .sending
  );

  sd_receiver u_sd_receiver (
    .clock, .reset, .sample_tick, .miso, .rx_start, .rx_kind,
    .rx_result, .rx_block, .rx_done
  );

  sd_clock_gen #(
    .SLOW_DIV(SLOW_DIV),
    .FAST_DIV(FAST_DIV)
  ) u_sd_clock_gen (
    .clock, .reset, .fast, .sck_enable, .sck, .shift_tick, .sample_tick
  );

endmodule

`default_nettype wire

/* tb/sd_card_model.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_card_model
  import sd_pkg::*;
(
  input  logic cs,
  input  logic sck,
  input  logic mosi,
  output logic miso
);

  localparam int RESP_GAP = 8;    // Ones before any response
  localparam int TOKEN_GAP = 16;  // Ones between R1 and the read token
  localparam int BUSY_BITS = 24;  // Programming time after a write

  logic        miso_q = 1'b1;
  logic [47:0] frame;
  int          frame_cnt = 0;
  logic        idle = 1'b1;
  int          acmd41_cnt = 0;
  int          fault_left = 0;
  logic        data_mode = 1'b0;
  logic        token_seen;
  logic [7:0]  tok;
  int          data_cnt;
  sd_block_t   wr_block;
  sd_addr_t    wr_addr;
  sd_crc16_t   crc_calc;
  sd_crc16_t   crc_rx;
  logic        out_q[$];       // Bits waiting to go out on MISO
  sd_block_t   mem[sd_addr_t];

  assign miso = miso_q;

  // Number of reads whose CRC16 gets corrupted from now on
  task automatic arm_faults(input int n);
    fault_left = n;
  endtask

  task automatic push_bits(input int n, input logic [31:0] v);
    for (int i = n - 1; i >= 0; i--) out_q.push_back(v[i]);
  endtask

  task automatic push_ones(input int n);
    repeat (n) out_q.push_back(1'b1);
  endtask

  function automatic sd_block_t fresh_block(input sd_addr_t a);
    sd_block_t blk;
    for (int i = 0; i < 512; i++) blk[i*8 +: 8] = a[7:0] ^ 8'(i);
    return blk;
  endfunction

  task automatic send_block(input sd_addr_t a);
    sd_block_t blk;
    sd_crc16_t crc;
    logic      b;
    blk = mem.exists(a) ? mem[a] : fresh_block(a);
    crc = '0;
    push_bits(8, DATA_START_TOKEN);
    for (int i = 0; i < BLOCK_BITS; i++) begin
      b = blk[(i / 8) * 8 + 7 - i % 8];  // MSB of each byte first
      out_q.push_back(b);
      crc = crc16_next(crc, b);
    end
    if (fault_left > 0) begin
      crc = crc ^ 16'h0001;
      fault_left--;
    end
    push_bits(16, crc);
  endtask

  task automatic serve_command();
    sd_crc7_t      crc;
    sd_cmd_index_t idx;
    sd_arg_t       arg;
    crc = '0;
    for (int i = 47; i >= 8; i--) crc = crc7_next(crc, frame[i]);
    idx = frame[45:40];
    arg = frame[39:8];
    push_ones(RESP_GAP);
    if (crc != frame[7:1]) begin
      push_bits(8, 8'h08);  // Command CRC error
    end else begin
      case (idx)
        6'd0: begin
          idle = 1'b1;
          acmd41_cnt = 0;
          push_bits(8, 8'h01);
        end
        6'd8: begin
          push_bits(8, {7'd0, idle});
          push_bits(32, {20'd0, arg[11:0]});  // Echo voltage and check pattern
        end
        6'd55: push_bits(8, {7'd0, idle});
        6'd41: begin
          acmd41_cnt++;
          if (acmd41_cnt > 2) idle = 1'b0;
          push_bits(8, {7'd0, idle});
        end
        6'd17: begin
          if (arg >= 32'h1000) begin
            push_bits(8, 8'h40);
          end else begin
            push_bits(8, 8'h00);
            push_ones(TOKEN_GAP);
            send_block(arg);
          end
        end
        6'd24: begin
          if (arg >= 32'h1000) begin
            push_bits(8, 8'h40);
          end else begin
            push_bits(8, 8'h00);
            data_mode = 1'b1;
            token_seen = 1'b0;
            tok = '1;
            wr_addr = arg;
          end
        end
        default: push_bits(8, 8'h04);  // Illegal command
      endcase
    end
  endtask

  task automatic take_data_bit(input logic d);
    if (!token_seen) begin
      tok = {tok[6:0], d};
      if (tok == DATA_START_TOKEN) begin
        token_seen = 1'b1;
        data_cnt = 0;
        crc_calc = '0;
      end
    end else begin
      if (data_cnt < BLOCK_BITS) begin
        wr_block[(data_cnt / 8) * 8 + 7 - data_cnt % 8] = d;
        crc_calc = crc16_next(crc_calc, d);
      end else begin
        crc_rx = {crc_rx[14:0], d};
      end
      data_cnt++;
      if (data_cnt == BLOCK_BITS + 16) begin
        data_mode = 1'b0;
        push_ones(RESP_GAP);
        if (crc_rx == crc_calc) begin
          mem[wr_addr] = wr_block;
          push_bits(8, 8'hE5);  // Data accepted
        end else begin
          push_bits(8, 8'hEB);  // CRC rejected
        end
        repeat (BUSY_BITS) out_q.push_back(1'b0);
      end
    end
  endtask

  // Card samples MOSI on the rising edge
  always @(posedge sck) begin
    if (!cs) begin
      if (data_mode) begin
        take_data_bit(mosi);
      end else if (frame_cnt > 0 || !mosi) begin
        frame = {frame[46:0], mosi};
        frame_cnt++;
        if (frame_cnt == 48) begin
          frame_cnt = 0;
          serve_command();
        end
      end
    end
  end

  always @(negedge sck or posedge cs) begin
    if (cs) begin
      out_q.delete();
      miso_q <= 1'b1;
    end else begin
      miso_q <= (out_q.size() > 0) ? out_q.pop_front() : 1'b1;
    end
  end

endmodule

`default_nettype wire

/* tb/sd_host_props.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_host_props
  import sd_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic busy,
  input logic done,
  input logic ready,
  input logic cs,
  input logic sck
);

  logic       sck_q;
  logic [7:0] pu_clocks;  // SCK rising edges seen with cs high, saturating

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sck_q     <= 1'b0;
      pu_clocks <= '0;
    end else begin
      sck_q <= sck;
      if (cs && sck && !sck_q && pu_clocks < 8'(POWER_UP_CLOCKS)) pu_clocks <= pu_clocks + 1'b1;
    end
  end

  a_done_ends_busy: assert property (@(posedge clock) disable iff (reset)
    done |-> $past(busy)) else $error("done pulse without an operation in progress");

  a_power_up_clocks: assert property (@(posedge clock) disable iff (reset)
    $fell(cs) |-> pu_clocks >= 8'(POWER_UP_CLOCKS)) else $error("cs fell before power-up clocks");

  a_busy_after_ready: assert property (@(posedge clock) disable iff (reset)
    $rose(busy) |-> ready) else $error("busy rose before initialisation finished");

endmodule

bind sd_host_top sd_host_props u_sd_host_props (
  .clock, .reset, .busy, .done, .ready, .cs, .sck
);

`default_nettype wire

/* tb/tb_sd_host.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sd_host
  import sd_pkg::*;
;

  localparam int SLOW_DIV = 4;
  localparam int FAST_DIV = 2;
  localparam int MAX_RETRIES = 2;
  localparam int BLOCK_CYCLES = (MAX_RETRIES + 2) * 4500 * 2 * FAST_DIV;  // Worst case per test
  localparam int INIT_CYCLES = 2500 * 2 * SLOW_DIV;
  localparam string TRACE_FILE = "tb/sd_trace.txt";

  logic      clock;
  logic      reset;
  logic      rd_en;
  logic      wr_en;
  sd_addr_t  addr;
  sd_block_t write_data;
  sd_block_t read_data;
  logic      busy;
  logic      done;
  logic      error;
  logic      ready;
  logic      miso;
  logic      cs;
  logic      sck;
  logic      mosi;

  logic [7:0] trace_op[$];
  sd_addr_t   trace_addr[$];
  logic [7:0] trace_seed[$];
  int         trace_faults[$];
  logic [7:0] written_seed[sd_addr_t];
  logic       trace_loaded = 1'b0;
  logic       load_ok;
  int         errors = 0;
  int         tests_passed = 0;
  int         done_count = 0;
  int         accepted = 0;
  int         wait_cycles;

  sd_host_top #(
    .SLOW_DIV(SLOW_DIV),
    .FAST_DIV(FAST_DIV),
    .MAX_RETRIES(MAX_RETRIES)
  ) u_sd_host_top (
    .clock, .reset, .rd_en, .wr_en, .addr, .write_data, .read_data,
    .busy, .done, .error, .ready, .miso, .cs, .sck, .mosi
  );

  sd_card_model u_card (.cs, .sck, .mosi, .miso);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) if (done) done_count++;

  function automatic sd_block_t seed_block(input logic [7:0] seed);
    sd_block_t blk;
    for (int i = 0; i < 512; i++) blk[i*8 +: 8] = seed + 8'(i);
    return blk;
  endfunction

  function automatic sd_block_t addr_block(input sd_addr_t a);
    sd_block_t blk;
    for (int i = 0; i < 512; i++) blk[i*8 +: 8] = a[7:0] ^ 8'(i);
    return blk;
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Shows the first byte that differs
  task automatic check_block(input string name, input sd_block_t got, input sd_block_t exp);
    int bad;
    bad = -1;
    for (int i = 511; i >= 0; i--) if (got[i*8 +: 8] !== exp[i*8 +: 8]) bad = i;
    if (bad >= 0) begin
      $display("FAILED %s byte %0d: got %h expected %h", name, bad,
               got[bad*8 +: 8], exp[bad*8 +: 8]);
      errors++;
    end
  endtask

  task automatic load_trace(output logic ok);
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    sd_addr_t   a;
    logic [7:0] s;
    int         f;
    ok = 1'b0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%c %h %h %d", op, a, s, f) == 4) begin
            trace_op.push_back(op);
            trace_addr.push_back(a);
            trace_seed.push_back(s);
            trace_faults.push_back(f);
          end
        end
      end
      $fclose(fd);
      ok = (trace_op.size() > 0);
    end
  endtask

  task automatic run_test(input int idx);
    logic       is_write;
    sd_addr_t   a;
    logic [7:0] s;
    int         f;
    logic       exp_err;
    sd_block_t  exp_blk;
    int         err_before;
    int         cycles;
    is_write = (trace_op[idx] == "W");
    a = trace_addr[idx];
    s = trace_seed[idx];
    f = trace_faults[idx];
    err_before = errors;
    exp_err = (a >= 32'h1000) || (!is_write && f > MAX_RETRIES);
    exp_blk = written_seed.exists(a) ? seed_block(written_seed[a]) : addr_block(a);
    u_card.arm_faults(is_write ? 0 : f);
    @(posedge clock);
    addr <= a;
    write_data <= seed_block(s);
    rd_en <= !is_write;
    wr_en <= is_write;
    @(posedge clock);
    rd_en <= 1'b0;
    wr_en <= 1'b0;
    accepted++;  // One request per test, issued while idle
    @(posedge clock);
    check_flag("busy", busy, 1'b1);
    // Stray request in the middle of the operation is dropped
    repeat (2) @(posedge clock);
    rd_en <= !is_write;
    wr_en <= is_write;
    @(posedge clock);
    rd_en <= 1'b0;
    wr_en <= 1'b0;
    cycles = 0;
    while (!done && cycles < BLOCK_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    if (done) begin
      check_flag("busy", busy, 1'b0);
      check_flag("error", error, exp_err);
      if (!is_write && !exp_err) check_block("read_data", read_data, exp_blk);
      if (is_write && !exp_err) written_seed[a] = s;
    end else begin
      $display("test %0d never signalled done", idx);
      errors++;
    end
    check_flag("ready", ready, 1'b1);
    if (errors == err_before) tests_passed++;
    $display("test %0d %s addr %h faults %0d: %s", idx, is_write ? "write" : "read", a, f,
             (errors == err_before) ? "ok" : "FAILED");
  endtask

  initial begin
    wait (trace_loaded);
    repeat (INIT_CYCLES + trace_op.size() * BLOCK_CYCLES) @(posedge clock);
    $display("watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    rd_en = 1'b0;
    wr_en = 1'b0;
    addr = '0;
    write_data = '0;
    load_trace(load_ok);
    if (!load_ok) begin
      $display("could not read any test from %s", TRACE_FILE);
      errors++;
    end else begin
      trace_loaded = 1'b1;
      repeat (5) @(posedge clock);
      reset <= 1'b0;
      @(posedge clock);
      check_flag("busy", busy, 1'b0);
      check_flag("done", done, 1'b0);
      check_flag("error", error, 1'b0);
      check_flag("ready", ready, 1'b0);
      check_flag("cs", cs, 1'b1);
      wait_cycles = 0;
      while (!ready && wait_cycles < INIT_CYCLES) begin
        @(posedge clock);
        wait_cycles++;
      end
      if (!ready) begin
        $display("card initialisation did not complete");
        errors++;
      end else begin
        for (int i = 0; i < trace_op.size(); i++) run_test(i);
        repeat (4) @(posedge clock);
        if (done_count != accepted) begin
          $display("FAILED done_count: got %h expected %h", done_count, accepted);
          errors++;
        end
      end
    end
    $display("%0d tests, %0d passed, %0d errors", trace_op.size(), tests_passed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/sd_trace.txt */
# op addr seed faults : op R reads a block, W writes one, addr and seed in hex
# faults is the number of reads whose CRC16 the card corrupts (decimal)
W 00000010 3C 0
R 00000010 00 0
R 00000022 00 0
W 00000100 A5 0
R 00000100 00 1
R 00000100 00 2
R 00000100 00 3
W 00001000 11 0
R 00002000 00 0
R 00000022 00 0
W 00000FFF 7E 0
R 00000FFF 00 0
R 00000010 00 0

/* tb.f */
logic/sd_pkg.sv
logic/sd_clock_gen.sv
logic/sd_sender.sv
logic/sd_receiver.sv
logic/sd_controller.sv
logic/sd_host_top.sv
tb/sd_card_model.sv
tb/sd_host_props.sv
tb/tb_sd_host.sv

/* Bender.yml */
package:
  name: sd_host

sources:
  - logic/sd_pkg.sv
  - logic/sd_clock_gen.sv
  - logic/sd_sender.sv
  - logic/sd_receiver.sv
  - logic/sd_controller.sv
  - logic/sd_host_top.sv
  - target: simulation
    files:
      - tb/sd_card_model.sv
      - tb/sd_host_props.sv
      - tb/tb_sd_host.sv
